// File: flist.f
rtl/reflet_pkg.sv
rtl/reflet_alu.sv
rtl/reflet_addr.sv
rtl/reflet_interrupt.sv
rtl/reflet_cpu.sv
verif/reflet_cpu_chk.sv
verif/reflet_tb.sv

// File: Bender.yml
package:
  name: reflet

sources:
  - rtl/reflet_pkg.sv
  - rtl/reflet_alu.sv
  - rtl/reflet_addr.sv
  - rtl/reflet_interrupt.sv
  - rtl/reflet_cpu.sv
  - target: simulation
    files:
      - verif/reflet_cpu_chk.sv
      - verif/reflet_tb.sv

// File: verif/reflet_tb.sv
`timescale 1ns/1ps
//****************************************
// Reflet CPU testbench
// Directed programs run from a byte memory
// model, results checked in memory
//****************************************

module reflet_tb
    import reflet_pkg::*;
();

    localparam logic [word_width-1:0] result_base = 16'h0300;
    localparam logic [word_width-1:0] target_addr = 16'h0080;
    localparam int                    wait_limit  = 2000;

    logic                  clk;
    logic                  reset;
    logic                  enable;
    logic [word_width-1:0] data_in;
    logic [3:0]            ext_int;
    logic [word_width-1:0] addr;
    logic [word_width-1:0] data_out;
    logic                  write_en;
    logic                  quit;
    logic                  debug;

    logic [7:0]            mem [0:1023];
    logic [9:0]            bus_addr;
    logic                  bus_we;
    logic                  bus_quit;
    logic [word_width-1:0] bus_wdata;
    int                    prog_ptr;
    int                    checks;
    int                    errors;
    int                    timeouts;
    int                    debug_count;
    int                    late_writes;
    integer                seed = 32'hf659;

    reflet_cpu u_dut (
        .clk      (clk),
        .reset    (reset),
        .enable   (enable),
        .data_in  (data_in),
        .addr     (addr),
        .data_out (data_out),
        .write_en (write_en),
        .quit     (quit),
        .debug    (debug),
        .ext_int  (ext_int)
    );

    always #20 clk = ~clk;

    // Bus memory, little endian words, read data one cycle after the address
    always @(posedge clk)
    begin
        bus_addr  = {addr[9:1], 1'b0};
        bus_we    = write_en;
        bus_quit  = quit;
        bus_wdata = data_out;
        #1;
        if (bus_we)
        begin
            mem[bus_addr]     = bus_wdata[7:0];
            mem[bus_addr + 1] = bus_wdata[15:8];
            if (bus_quit)
                late_writes++;
        end
        data_in = {mem[bus_addr + 1], mem[bus_addr]};
    end

    always @(posedge clk)
    begin
        if (reset === 1'b1 && debug === 1'b1)
            debug_count++;
    end

    task automatic check_word(input logic [word_width-1:0] actual,
                              input logic [word_width-1:0] expected, input string what);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %h, expected %h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %b, expected %b",
                     $time, what, actual, expected);
        end
    endtask

    function automatic logic [word_width-1:0] read_word(input int byte_addr);
        return {mem[byte_addr + 1], mem[byte_addr]};
    endfunction

    task automatic clear_memory();
        for (int i = 0; i < 1024; i++)
            mem[i] = 8'h00;
        prog_ptr = 0;
    endtask

    task automatic emit(input logic [3:0] opcode, input logic [3:0] arg);
        reflet_instr_u instr;
        instr.op.opcode = opcode;
        instr.op.arg    = arg;
        mem[prog_ptr]   = instr.code;
        prog_ptr++;
    endtask

    task automatic emit_code(input logic [7:0] code);
        mem[prog_ptr] = code;
        prog_ptr++;
    endtask

    // Builds a 12-bit constant a nibble at a time, R15 and R11 as scratch
    task automatic emit_const(input logic [word_width-1:0] value, input logic [3:0] dest);
        emit(op_set, 4'd4);
        emit(op_cpy, 4'd15);
        emit(op_set, value[11:8]);
        emit(op_lsl, 4'd15);
        emit(op_cpy, 4'd11);
        emit(op_set, value[7:4]);
        emit(op_or, 4'd11);
        emit(op_lsl, 4'd15);
        emit(op_cpy, 4'd11);
        emit(op_set, value[3:0]);
        emit(op_or, 4'd11);
        emit(op_cpy, dest);
    endtask

    // Store at R3, then R3 moves to the next word
    task automatic emit_store_next();
        emit(op_str, 4'd3);
        emit(op_set, 4'd2);
        emit(op_add, 4'd3);
        emit(op_cpy, 4'd3);
    endtask

    task automatic start_program();
        @(posedge clk);
        #1;
        reset       = 1'b0;
        debug_count = 0;
        late_writes = 0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b1;
    endtask

    task automatic wait_for_quit();
        int cycles;
        cycles = 0;
        while (quit !== 1'b1 && cycles < wait_limit)
        begin
            @(negedge clk);
            cycles++;
        end
        if (quit !== 1'b1)
        begin
            timeouts++;
            $display("Timeout at %0t: the program never raised quit", $time);
        end
    endtask

    task automatic wait_for_addr(input logic [word_width-1:0] target);
        int cycles;
        cycles = 0;
        while (addr !== target && cycles < wait_limit)
        begin
            @(negedge clk);
            cycles++;
        end
        if (addr !== target)
        begin
            timeouts++;
            $display("Timeout at %0t: the bus never reached address %h", $time, target);
        end
    endtask

    // Returns in the first cycle of a bus write, before the write edge
    task automatic wait_for_write();
        int cycles;
        cycles = 0;
        while (write_en !== 1'b1 && cycles < wait_limit)
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (write_en !== 1'b1)
        begin
            timeouts++;
            $display("Timeout at %0t: the program never wrote to memory", $time);
        end
    endtask

    task automatic run_program();
        start_program();
        wait_for_quit();
    endtask

    task automatic pulse_line(input int line);
        @(posedge clk);
        #1;
        ext_int[line] = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        ext_int[line] = 1'b0;
    endtask

    task automatic test_alu();
        logic [word_width-1:0] a;
        logic [word_width-1:0] b;
        logic [3:0]            ops [8];
        logic [word_width-1:0] expected [8];
        a        = 16'($random(seed) & 15);
        b        = 16'($random(seed) & 15);
        ops      = '{op_add, op_sub, op_and, op_or, op_xor, op_not, op_lsl, op_lsr};
        expected = '{a + b, a - b, a & b, a | b, a ^ b, ~b, a << b[3:0], a >> b[3:0]};
        clear_memory();
        emit_const(result_base, 4'd3);
        emit(op_set, a[3:0]);
        emit(op_cpy, 4'd1);
        emit(op_set, b[3:0]);
        emit(op_cpy, 4'd2);
        for (int i = 0; i < 8; i++)
        begin
            emit(op_read, 4'd1);
            emit(ops[i], 4'd2);
            emit_store_next();
        end
        emit_code(sp_quit);
        run_program();
        for (int i = 0; i < 8; i++)
            check_word(read_word(result_base + 2 * i), expected[i],
                       $sformatf("ALU opcode %0d on %h and %h", ops[i], a, b));
    endtask

    // Marker 2 on the taken path at target_addr, marker 1 on fall through
    task automatic test_branch(input logic [3:0] cmp_op, input logic [3:0] x,
                               input logic [3:0] y);
        logic taken;
        clear_memory();
        emit_const(result_base, 4'd3);
        emit(op_set, x);
        emit(op_cpy, 4'd1);
        emit(op_set, y);
        emit(op_cpy, 4'd2);
        emit_const(target_addr, 4'd5);
        emit(op_read, 4'd1);
        emit(cmp_op, 4'd2);
        emit(op_read, 4'd5);
        emit_code(sp_jif);
        emit(op_set, 4'd1);
        emit(op_str, 4'd3);
        emit_code(sp_quit);
        prog_ptr = target_addr;
        emit(op_set, 4'd2);
        emit(op_str, 4'd3);
        emit_code(sp_quit);
        run_program();
        taken = (cmp_op == op_eq) ? (x == y) : (x < y);
        check_word(read_word(result_base), taken ? 16'd2 : 16'd1,
                   $sformatf("branch marker, opcode %0d on %h and %h", cmp_op, x, y));
    endtask

    task automatic test_stack();
        logic [3:0] a;
        logic [3:0] b;
        logic [3:0] c;
        int         ret_addr;
        a = 4'($random(seed));
        b = 4'($random(seed));
        c = 4'($random(seed));
        clear_memory();
        emit_const(result_base, 4'd3);
        emit(op_set, a);
        emit_code(sp_push);
        emit(op_set, b);
        emit_code(sp_push);
        emit_code(sp_pop);
        emit(op_cpy, 4'd1);
        emit_code(sp_pop);
        emit(op_cpy, 4'd2);
        emit_const(target_addr, wr_id);
        emit_code(sp_call);
        ret_addr = prog_ptr;
        emit(op_read, 4'd1);
        emit_store_next();
        emit(op_read, 4'd2);
        emit_store_next();
        emit(op_read, 4'd4);
        emit_store_next();
        emit(op_read, sp_id);
        emit_store_next();
        emit_const(sp_reset + word_bytes, 4'd5);
        emit(op_load, 4'd5);
        emit_store_next();
        emit_code(sp_quit);
        // Subroutine
        prog_ptr = target_addr;
        emit(op_set, c);
        emit(op_cpy, 4'd4);
        emit_code(sp_ret);
        run_program();
        check_word(read_word(result_base), {12'd0, b}, "first pop");
        check_word(read_word(result_base + 2), {12'd0, a}, "second pop");
        check_word(read_word(result_base + 4), {12'd0, c}, "value set in subroutine");
        check_word(read_word(result_base + 6), sp_reset, "final stack pointer");
        check_word(read_word(result_base + 8), {12'd0, b}, "load from stack area");
        check_word(read_word(sp_reset), 16'(ret_addr), "return address pushed by call");
        check_word(read_word(sp_reset + word_bytes), {12'd0, b}, "second pushed word");
    endtask

    // Spin loop at target_addr exits once the routine changes R6
    task automatic test_interrupt();
        int n;
        int m;
        n = $random(seed) & 3;
        m = (n + 1) % 4;
        clear_memory();
        emit_const(result_base, 4'd8);
        emit_const(result_base + 2, 4'd9);
        emit_const(result_base + 4, 4'd7);
        emit(op_set, 4'(sr_mask_low + n));
        emit(op_cpy, 4'd1);
        emit(op_set, 4'd1);
        emit(op_lsl, 4'd1);
        emit(op_cpy, sr_id);
        emit_const(target_addr, 4'd6);
        emit(op_eq, wr_id);
        emit_code(sp_jif);
        prog_ptr = target_addr;
        emit(op_eq, 4'd6);
        emit_code(sp_jif);
        emit(op_str, 4'd7);
        emit_code(sp_quit);
        prog_ptr = int_base + n * int_stride;
        emit(op_set, 4'd9);
        emit(op_str, 4'd8);
        emit(op_cpy, 4'd6);
        emit_code(sp_retint);
        prog_ptr = int_base + m * int_stride;
        emit(op_set, 4'd5);
        emit(op_str, 4'd9);
        emit_code(sp_retint);
        start_program();
        wait_for_addr(target_addr);
        pulse_line(m);
        pulse_line(n);
        wait_for_quit();
        check_word(read_word(result_base), 16'd9, $sformatf("marker of line %0d", n));
        check_word(read_word(result_base + 2), 16'd0, $sformatf("masked line %0d", m));
        check_word(read_word(result_base + 4), target_addr, "restored working register");
    endtask

    task automatic test_enable();
        clear_memory();
        emit_const(result_base, 4'd3);
        for (int i = 1; i <= 4; i++)
        begin
            emit(op_set, 4'(i));
            emit_store_next();
            if (i == 2)
                emit_code(sp_debug);
        end
        emit_code(sp_quit);
        // Never reached once quit stops the CPU
        emit(op_str, 4'd3);
        start_program();
        wait_for_write();
        enable = 1'b0;
        repeat (8)
        begin
            @(negedge clk);
            check_flag(write_en, 1'b0, "write_en while enable is low");
        end
        @(posedge clk);
        #1;
        enable = 1'b1;
        wait_for_quit();
        for (int i = 0; i < 4; i++)
            check_word(read_word(result_base + 2 * i), 16'(i + 1), "store around the stall");
        check_flag(debug_count == 1, 1'b1, "single debug pulse");
        // Watch the bus for a while after quit
        repeat (10) @(negedge clk);
        check_flag(quit, 1'b1, "quit held high");
        check_flag(late_writes == 0, 1'b1, "no write after quit");
    endtask

    initial
    begin
        logic [3:0] x;
        logic [3:0] y;
        logic       pick;
        clk      = 1'b0;
        reset    = 1'b0;
        enable   = 1'b1;
        data_in  = '0;
        ext_int  = '0;
        checks   = 0;
        errors   = 0;
        timeouts = 0;
        test_alu();
        x = 4'($random(seed));
        test_branch(op_eq, x, x);
        repeat (4)
        begin
            x    = 4'($random(seed));
            y    = 4'($random(seed));
            pick = 1'($random(seed));
            test_branch(pick ? op_les : op_eq, x, y);
        end
        test_stack();
        test_interrupt();
        test_enable();
        $display("Checks: %0d  errors: %0d  timeouts: %0d  assertion failures: %0d",
                 checks, errors, timeouts, u_dut.u_chk.failures);
        if (errors == 0 && timeouts == 0 && u_dut.u_chk.failures == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: verif/reflet_cpu_chk.sv
`timescale 1ns/1ps
//****************************************
// Reflet CPU checker
// Assertions on bus writes and quit
//****************************************

module reflet_cpu_chk (
    input logic clk,
    input logic reset,
    input logic enable,
    input logic write_en,
    input logic quit
);

    int failures = 0;

    // No bus write in reset or while stalled
    assert property (@(posedge clk) (!reset || !enable) |-> !write_en)
    else
    begin
        failures++;
        $error("write_en high during reset or with enable low");
    end

    // Quit is sticky until the next reset
    assert property (@(posedge clk) disable iff (!reset) quit |=> quit)
    else
    begin
        failures++;
        $error("quit fell outside reset");
    end

    assert property (@(posedge clk) quit |-> !write_en)
    else
    begin
        failures++;
        $error("bus write after quit");
    end

endmodule

bind reflet_cpu reflet_cpu_chk u_chk (
    .clk      (clk),
    .reset    (reset),
    .enable   (enable),
    .write_en (write_en),
    .quit     (quit)
);

// File: rtl/reflet_cpu.sv
`timescale 1ns/1ps
//****************************************
// Reflet CPU top
// Register file, update control and the
// quit and debug outputs
//****************************************

module reflet_cpu
    import reflet_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  enable,
    input  logic [word_width-1:0] data_in,
    output logic [word_width-1:0] addr,
    output logic [word_width-1:0] data_out,
    output logic                  write_en,
    output logic                  quit,
    output logic                  debug,
    input  logic [3:0]            ext_int
);

    logic [word_width-1:0] registers [16];
    reflet_instr_u         instruction;
    logic                  run;
    logic                  ram_not_ready;
    logic                  cpu_update;
    logic                  interrupt;
    logic                  restore_cycle;
    logic                  reg_write;
    logic [word_width-1:0] int_routine;
    logic [word_width-1:0] out_alu;
    logic [word_width-1:0] out_addr;
    logic [word_width-1:0] out_int;
    logic [word_width-1:0] content;
    logic [3:0]            reg_alu;
    logic [3:0]            reg_addr;
    logic [3:0]            reg_int;
    logic [3:0]            index;

    // Everything stops once quit is set
    assign run        = enable && !quit;
    assign cpu_update = !ram_not_ready;

    // Idle blocks drive zero
    assign content = out_alu | out_addr | out_int;
    assign index   = reg_alu | reg_addr | reg_int;

    reflet_alu alu (
        .working_register (registers[wr_id]),
        .other_register   (registers[instruction.op.arg]),
        .status_register  (registers[sr_id]),
        .instruction      (instruction),
        .out              (out_alu),
        .out_reg          (reg_alu)
    );

    reflet_addr bus_if (
        .clk              (clk),
        .reset            (reset),
        .enable           (run),
        .working_register (registers[wr_id]),
        .program_counter  (registers[pc_id]),
        .stack_pointer    (registers[sp_id]),
        .other_register   (registers[instruction.op.arg]),
        .data_in          (data_in),
        .addr             (addr),
        .data_out         (data_out),
        .write_en         (write_en),
        .instruction      (instruction),
        .out              (out_addr),
        .out_reg          (reg_addr),
        .ram_not_ready    (ram_not_ready)
    );

    reflet_interrupt int_ctrl (
        .clk              (clk),
        .reset            (reset),
        .enable           (run),
        .ext_int          (ext_int),
        .instruction      (instruction),
        .working_register (registers[wr_id]),
        .program_counter  (registers[pc_id]),
        .int_mask         (registers[sr_id][sr_mask_low +: 4]),
        .cpu_update       (cpu_update),
        .out              (out_int),
        .out_reg          (reg_int),
        .out_routine      (int_routine),
        .interrupt        (interrupt)
    );

    // Does the completing instruction write a register
    always_comb
    begin
        case (instruction.code)
            sp_pop, sp_ret, sp_call, sp_retint:
                reg_write = 1'b1;
            sp_jif:
                reg_write = registers[sr_id][sr_cmp_bit];
            default:
                reg_write = instruction.op.opcode != op_special &&
                            instruction.op.opcode != op_str;
        endcase
    end

    assign debug = cpu_update && !interrupt && instruction.code == sp_debug;

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            registers[wr_id] <= wr_reset;
            for (int i = gp_first; i <= gp_last; i++)
                registers[i] <= gp_reset;
            registers[15]    <= gp_reset;
            registers[sr_id] <= sr_reset;
            registers[sp_id] <= sp_reset;
            registers[pc_id] <= pc_reset;
            quit             <= 1'b0;
            restore_cycle    <= 1'b0;
        end
        else if (run)
        begin
            restore_cycle <= cpu_update && !interrupt && instruction.code == sp_retint;
            // Second half of retint brings the working register back
            if (restore_cycle)
                registers[index] <= content;
            if (cpu_update && interrupt)
                registers[pc_id] <= int_routine;
            else if (cpu_update)
            begin
                if (reg_write)
                    registers[index] <= content;
                case (instruction.code)
                    sp_push, sp_call:
                        registers[sp_id] <= registers[sp_id] + word_bytes;
                    sp_pop, sp_ret:
                        registers[sp_id] <= registers[sp_id] - word_bytes;
                    sp_quit:
                        quit <= 1'b1;
                    default:
                        quit <= 1'b0;
                endcase
                // A jump already sets the PC
                if (!(reg_write && index == pc_id))
                    registers[pc_id] <= registers[pc_id] + 1'b1;
            end
        end
    end

endmodule

// File: rtl/reflet_interrupt.sv
`timescale 1ns/1ps
//****************************************
// Reflet interrupt controller
// Edge capture, masking, priority and
// context save and restore
//****************************************

module reflet_interrupt
    import reflet_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  enable,
    input  logic [3:0]            ext_int,
    input  reflet_instr_u         instruction,
    input  logic [word_width-1:0] working_register,
    input  logic [word_width-1:0] program_counter,
    input  logic [3:0]            int_mask,
    input  logic                  cpu_update,
    output logic [word_width-1:0] out,
    output logic [3:0]            out_reg,
    output logic [word_width-1:0] out_routine,
    output logic                  interrupt
);

    logic [3:0]            ext_prev;
    logic [3:0]            pending;
    logic [3:0]            ready;
    logic [3:0]            accepted;
    logic [1:0]            int_num;
    logic                  in_service;
    logic                  restore_wr;
    logic                  is_retint;
    logic [word_width-1:0] saved_wr;
    logic [word_width-1:0] saved_pc;

    assign ready     = pending & int_mask;
    assign is_retint = instruction.code == sp_retint;

    // Lowest line wins
    always_comb
    begin
        int_num = '0;
        for (int n = 3; n >= 0; n--)
        begin
            if (ready[n])
                int_num = 2'(n);
        end
    end

    assign interrupt   = cpu_update && !in_service && (|ready);
    assign accepted    = interrupt ? (4'b0001 << int_num) : 4'b0000;
    assign out_routine = int_base + word_width'(int_num) * int_stride;

    // PC returns at completion, working register one cycle later
    always_comb
    begin
        out     = '0;
        out_reg = '0;
        if (cpu_update && is_retint)
        begin
            out     = saved_pc;
            out_reg = pc_id;
        end
        else if (restore_wr)
        begin
            out     = saved_wr;
            out_reg = wr_id;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            ext_prev   <= '0;
            pending    <= '0;
            in_service <= 1'b0;
            restore_wr <= 1'b0;
        end
        else if (enable)
        begin
            ext_prev   <= ext_int;
            pending    <= (pending | (ext_int & ~ext_prev)) & ~accepted;
            restore_wr <= cpu_update && is_retint;
            if (interrupt)
                in_service <= 1'b1;
            else if (cpu_update && is_retint)
                in_service <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (enable && interrupt)
        begin
            saved_wr <= working_register;
            saved_pc <= program_counter;
        end
    end

endmodule

// File: rtl/reflet_addr.sv
`timescale 1ns/1ps
//****************************************
// Reflet bus interface
// Instruction fetch plus load, store,
// stack, call and return accesses
//****************************************

module reflet_addr
    import reflet_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  enable,
    input  logic [word_width-1:0] working_register,
    input  logic [word_width-1:0] program_counter,
    input  logic [word_width-1:0] stack_pointer,
    input  logic [word_width-1:0] other_register,
    input  logic [word_width-1:0] data_in,
    output logic [word_width-1:0] addr,
    output logic [word_width-1:0] data_out,
    output logic                  write_en,
    output reflet_instr_u         instruction,
    output logic [word_width-1:0] out,
    output logic [3:0]            out_reg,
    output logic                  ram_not_ready
);

    logic [1:0]            state;
    reflet_instr_u         fetched;
    reflet_instr_u         held;
    logic                  is_load;
    logic                  is_str;
    logic                  is_push;
    logic                  is_pop;
    logic                  is_call;
    logic                  is_ret;
    logic                  mem_read;
    logic                  mem_write;
    logic                  complete;
    logic [word_width-1:0] data_addr;

    // Even PC takes the low byte of the fetched word
    assign fetched = program_counter[0] ? data_in[15:8] : data_in[7:0];
    assign instruction = (state == st_fetch_wait) ? fetched : held;

    assign is_load   = instruction.op.opcode == op_load;
    assign is_str    = instruction.op.opcode == op_str;
    assign is_push   = instruction.code == sp_push;
    assign is_pop    = instruction.code == sp_pop;
    assign is_call   = instruction.code == sp_call;
    assign is_ret    = instruction.code == sp_ret;
    assign mem_read  = is_load | is_pop | is_ret;
    assign mem_write = is_str | is_push | is_call;

    // Pops read one word below the stack pointer
    always_comb
    begin
        if (is_load || is_str)
            data_addr = other_register;
        else if (is_pop || is_ret)
            data_addr = stack_pointer - word_bytes;
        else
            data_addr = stack_pointer;
    end

    always_comb
    begin
        addr     = '0;
        data_out = '0;
        write_en = 1'b0;
        out      = '0;
        out_reg  = '0;
        complete = 1'b0;
        case (state)
            st_fetch:
                addr = {program_counter[word_width-1:1], 1'b0};
            st_fetch_wait:
                complete = !(mem_read || mem_write);
            st_data:
            begin
                addr     = {data_addr[word_width-1:1], 1'b0};
                data_out = is_call ? program_counter + 1'b1 : working_register;
                write_en = mem_write && enable;
                complete = mem_write;
                // Call jumps to the working register
                if (is_call)
                begin
                    out     = working_register;
                    out_reg = pc_id;
                end
            end
            st_data_wait:
            begin
                complete = 1'b1;
                out      = data_in;
                out_reg  = is_ret ? pc_id : wr_id;
            end
            default:
                complete = 1'b0;
        endcase
    end

    assign ram_not_ready = !(complete && enable);

    always_ff @(posedge clk)
    begin
        if (!reset)
            state <= st_fetch;
        else if (enable)
        begin
            case (state)
                st_fetch:
                    state <= st_fetch_wait;
                st_fetch_wait:
                    state <= (mem_read || mem_write) ? st_data : st_fetch;
                st_data:
                    state <= mem_write ? st_fetch : st_data_wait;
                default:
                    state <= st_fetch;
            endcase
        end
    end

    // Byte stays valid through the data states
    always_ff @(posedge clk)
    begin
        if (enable && state == st_fetch_wait)
            held <= fetched;
    end

endmodule

// File: rtl/reflet_alu.sv
`timescale 1ns/1ps
//****************************************
// Reflet ALU
// Register update for arithmetic, logic,
// shift, compare, move and jif
//****************************************

module reflet_alu
    import reflet_pkg::*;
(
    input  logic [word_width-1:0] working_register,
    input  logic [word_width-1:0] other_register,
    input  logic [word_width-1:0] status_register,
    input  reflet_instr_u         instruction,
    output logic [word_width-1:0] out,
    output logic [3:0]            out_reg
);

    logic                  cmp_result;
    logic [word_width-1:0] cmp_status;

    // Compare flag replaced, mask bits kept
    always_comb
    begin
        if (instruction.op.opcode == op_eq)
            cmp_result = working_register == other_register;
        else
            cmp_result = working_register < other_register;
        cmp_status = status_register;
        cmp_status[sr_cmp_bit] = cmp_result;
    end

    always_comb
    begin
        // Most opcodes target the working register
        out     = '0;
        out_reg = wr_id;
        case (instruction.op.opcode)
            op_set:
                out = {{(word_width-4){1'b0}}, instruction.op.arg};
            op_read:
                out = other_register;
            op_cpy:
            begin
                out     = working_register;
                out_reg = instruction.op.arg;
            end
            op_add:
                out = working_register + other_register;
            op_sub:
                out = working_register - other_register;
            op_and:
                out = working_register & other_register;
            op_or:
                out = working_register | other_register;
            op_xor:
                out = working_register ^ other_register;
            op_not:
                out = ~other_register;
            op_lsl:
                out = working_register << other_register[3:0];
            op_lsr:
                out = working_register >> other_register[3:0];
            op_eq, op_les:
            begin
                out     = cmp_status;
                out_reg = sr_id;
            end
            op_special:
            begin
                case (instruction.code)
                    sp_jif:
                    begin
                        if (status_register[sr_cmp_bit])
                        begin
                            out     = working_register;
                            out_reg = pc_id;
                        end
                    end
                    // No register update
                    default:
                        out = '0;
                endcase
            end
            // Memory opcodes belong to the bus interface
            default:
                out = '0;
        endcase
    end

endmodule

// File: rtl/reflet_pkg.sv
//****************************************
// Reflet shared definitions
// Word size, register map, opcodes,
// reset values and the instruction byte
//****************************************

package reflet_pkg;

    // Data and address width
    localparam int word_width = 16;
    localparam logic [word_width-1:0] word_bytes = 2;

    // Register map
    localparam logic [3:0] wr_id    = 4'd0;
    localparam logic [3:0] gp_first = 4'd1;
    localparam logic [3:0] gp_last  = 4'd11;
    localparam logic [3:0] sr_id    = 4'd12;
    localparam logic [3:0] sp_id    = 4'd13;
    localparam logic [3:0] pc_id    = 4'd14;

    // Reset values
    localparam logic [word_width-1:0] pc_reset = 16'h0000;
    localparam logic [word_width-1:0] sp_reset = 16'h0200;
    localparam logic [word_width-1:0] sr_reset = 16'h0000;
    localparam logic [word_width-1:0] wr_reset = 16'h0000;
    localparam logic [word_width-1:0] gp_reset = 16'h0000;

    // Status register layout, mask bit 3+n enables interrupt n
    localparam int sr_cmp_bit  = 0;
    localparam int sr_mask_low = 3;

    // Opcode nibbles
    localparam logic [3:0] op_special = 4'd0;
    localparam logic [3:0] op_set     = 4'd1;
    localparam logic [3:0] op_read    = 4'd2;
    localparam logic [3:0] op_cpy     = 4'd3;
    localparam logic [3:0] op_add     = 4'd4;
    localparam logic [3:0] op_sub     = 4'd5;
    localparam logic [3:0] op_and     = 4'd6;
    localparam logic [3:0] op_or      = 4'd7;
    localparam logic [3:0] op_xor     = 4'd8;
    localparam logic [3:0] op_not     = 4'd9;
    localparam logic [3:0] op_lsl     = 4'd10;
    localparam logic [3:0] op_lsr     = 4'd11;
    localparam logic [3:0] op_eq      = 4'd12;
    localparam logic [3:0] op_les     = 4'd13;
    localparam logic [3:0] op_str     = 4'd14;
    localparam logic [3:0] op_load    = 4'd15;

    // Whole-byte codes under op_special
    localparam logic [7:0] sp_slp    = 8'h00;
    localparam logic [7:0] sp_jif    = 8'h02;
    localparam logic [7:0] sp_pop    = 8'h03;
    localparam logic [7:0] sp_push   = 8'h04;
    localparam logic [7:0] sp_call   = 8'h05;
    localparam logic [7:0] sp_ret    = 8'h06;
    localparam logic [7:0] sp_quit   = 8'h07;
    localparam logic [7:0] sp_debug  = 8'h08;
    localparam logic [7:0] sp_retint = 8'h09;

    // Interrupt routine n starts at int_base + n * int_stride
    localparam logic [word_width-1:0] int_base   = 16'h0100;
    localparam logic [word_width-1:0] int_stride = 16'd16;

    // Bus interface states
    localparam logic [1:0] st_fetch      = 2'd0;
    localparam logic [1:0] st_fetch_wait = 2'd1;
    localparam logic [1:0] st_data       = 2'd2;
    localparam logic [1:0] st_data_wait  = 2'd3;

    // Instruction byte, opcode plus argument or a whole special code
    typedef union packed {
        struct packed {
            logic [3:0] opcode;
            logic [3:0] arg;
        } op;
        logic [7:0] code;
    } reflet_instr_u;

endpackage
